//--- common/lstm_config.svh
`ifndef LSTM_CONFIG_SVH
`define LSTM_CONFIG_SVH

// Q4.12 fixed-point word
`define DATA_WIDTH 16

// fraction bits of one word
`define FRAC_BITS 12

// hidden neurons, lanes per row and rows per layer
// must stay a power of two for the adder tree
`define ARRAY_DEPTH 64

// input register plus the two multiplier stages
`define MUL_STAGES 3

`endif

//--- common/lstm_pkg.sv
`include "lstm_config.svh"

package lstm_pkg;

	// one signed Q4.12 word
	typedef logic signed [`DATA_WIDTH-1:0] fixed_t;

	// row number within a layer
	typedef logic [$clog2(`ARRAY_DEPTH)-1:0] row_index_t;

	// exact sum of ARRAY_DEPTH lane products
	typedef logic signed [`DATA_WIDTH+$clog2(`ARRAY_DEPTH)-1:0] tree_sum_t;

endpackage

//--- source/signed_mul.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module signed_mul (
	input  logic             clk,
	input  lstm_pkg::fixed_t a,
	input  lstm_pkg::fixed_t b,
	output lstm_pkg::fixed_t c
);

	localparam int DW = `DATA_WIDTH;
	localparam int FB = `FRAC_BITS;

	logic [DW-1:0]   a_mag;
	logic [DW-1:0]   b_mag;
	logic [DW-1:0]   a_mag_q;
	logic [DW-1:0]   b_mag_q;
	logic            a_sign_q;
	logic            b_sign_q;
	logic [2*DW-1:0] prod_q;
	logic            a_sign_qq;
	logic            b_sign_qq;
	logic [DW-2:0]   prod_slice;
	logic [DW-1:0]   prod_mag;

	assign a_mag = a[DW-1] ? -a : a; // -32768 stays 0x8000
	assign b_mag = b[DW-1] ? -b : b;

	always_ff @(posedge clk) begin
		a_mag_q  <= a_mag;
		b_mag_q  <= b_mag;
		a_sign_q <= a[DW-1];
		b_sign_q <= b[DW-1];
	end

	always_ff @(posedge clk) begin
		prod_q    <= a_mag_q * b_mag_q; // unsigned 32 bit product
		a_sign_qq <= a_sign_q;
		b_sign_qq <= b_sign_q;
	end

	// integer bits above bit 26 are dropped, fraction truncated
	assign prod_slice = prod_q[DW+FB-2:FB];
	assign prod_mag   = {1'b0, prod_slice};
	assign c          = (a_sign_qq ^ b_sign_qq) ? -prod_mag : prod_mag;

endmodule

//--- vecmat/vecmat_mul_h.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module vecmat_mul_h (
	input  logic                                 clk,
	input  logic                                 load,
	input  lstm_pkg::fixed_t [`ARRAY_DEPTH-1:0] data,
	input  lstm_pkg::fixed_t [`ARRAY_DEPTH-1:0] weights,
	output lstm_pkg::fixed_t [`ARRAY_DEPTH-1:0] products
);

	import lstm_pkg::*;

	fixed_t [`ARRAY_DEPTH-1:0] state_q;  // hidden state h
	fixed_t [`ARRAY_DEPTH-1:0] weight_q; // current weight row

	// operands only change on a new row
	always_ff @(posedge clk) begin
		if (load) begin
			state_q  <= data;
			weight_q <= weights;
		end
	end

	genvar lane;
	generate
		for (lane = 0; lane < `ARRAY_DEPTH; lane++) begin : g_lane
			signed_mul u_mul (
				.clk (clk),
				.a   (state_q[lane]),
				.b   (weight_q[lane]),
				.c   (products[lane])
			);
		end
	endgenerate

endmodule

//--- vecmat/vecmat_add_tree.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module vecmat_add_tree (
	input  logic                                 clk,
	input  lstm_pkg::fixed_t [`ARRAY_DEPTH-1:0] terms,
	output lstm_pkg::fixed_t                     sum
);

	import lstm_pkg::*;

	localparam int TREE_STAGES = $clog2(`ARRAY_DEPTH);
	localparam int DW          = `DATA_WIDTH;

	localparam tree_sum_t SUM_MAX = (tree_sum_t'(1) <<< (DW - 1)) - tree_sum_t'(1);
	localparam tree_sum_t SUM_MIN = -(tree_sum_t'(1) <<< (DW - 1));

	tree_sum_t total; // full precision result of the last pair

	function automatic fixed_t saturate(input tree_sum_t value);
		fixed_t result;
		if (value > SUM_MAX) begin
			result = SUM_MAX[DW-1:0];
		end else if (value < SUM_MIN) begin
			result = SUM_MIN[DW-1:0];
		end else begin
			result = value[DW-1:0];
		end
		return result;
	endfunction

	// all but the last stage, each halves the node count
	genvar s;
	generate
		for (s = 0; s < TREE_STAGES - 1; s++) begin : g_stage
			localparam int NODES = `ARRAY_DEPTH >> (s + 1);

			tree_sum_t node [NODES];

			if (s == 0) begin : g_first
				always_ff @(posedge clk) begin
					for (int i = 0; i < NODES; i++) begin
						node[i] <= tree_sum_t'(terms[2*i]) + tree_sum_t'(terms[2*i+1]);
					end
				end
			end else begin : g_inner
				always_ff @(posedge clk) begin
					for (int i = 0; i < NODES; i++) begin
						node[i] <= g_stage[s-1].node[2*i] + g_stage[s-1].node[2*i+1];
					end
				end
			end
		end

		// root pair comes straight from the inputs for a two lane array
		if (TREE_STAGES == 1) begin : g_root_direct
			assign total = tree_sum_t'(terms[0]) + tree_sum_t'(terms[1]);
		end else begin : g_root
			assign total = g_stage[TREE_STAGES-2].node[0] + g_stage[TREE_STAGES-2].node[1];
		end
	endgenerate

	// clamp before the output register
	always_ff @(posedge clk) begin
		sum <= saturate(total);
	end

endmodule

//--- source/row_sequencer.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module row_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 row_valid,
	output logic                 dot_valid,
	output lstm_pkg::row_index_t dot_index,
	output logic                 layer_done
);

	import lstm_pkg::*;

	localparam int TREE_STAGES = $clog2(`ARRAY_DEPTH);
	localparam int LATENCY     = `MUL_STAGES + TREE_STAGES;

	localparam row_index_t LAST_ROW = row_index_t'(`ARRAY_DEPTH - 1);

	logic [LATENCY-1:0] valid_pipe; // one bit per row in flight
	row_index_t         row_count;

	// tracks the datapath latency only, no data passes here
	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[LATENCY-2:0], row_valid};
		end
	end

	assign dot_valid = valid_pipe[LATENCY-1];

	always_ff @(posedge clk) begin
		if (!reset) begin
			row_count <= '0;
		end else if (dot_valid) begin
			if (row_count == LAST_ROW) begin
				row_count <= '0; // next layer
			end else begin
				row_count <= row_count + row_index_t'(1);
			end
		end
	end

	assign dot_index  = row_count;
	assign layer_done = dot_valid && (row_count == LAST_ROW);

endmodule

//--- source/lstm_matvec_top.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module lstm_matvec_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 row_valid,
	input  lstm_pkg::fixed_t [`ARRAY_DEPTH-1:0] h_vec,
	input  lstm_pkg::fixed_t [`ARRAY_DEPTH-1:0] w_row,
	output lstm_pkg::fixed_t                     dot,
	output logic                                 dot_valid,
	output lstm_pkg::row_index_t                 dot_index,
	output logic                                 layer_done
);

	import lstm_pkg::*;

	fixed_t [`ARRAY_DEPTH-1:0] lane_products; // multiplier array to tree

	// control path, valid and row tagging
	row_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.row_valid  (row_valid),
		.dot_valid  (dot_valid),
		.dot_index  (dot_index),
		.layer_done (layer_done)
	);

	// lane by lane products of h and one weight row
	vecmat_mul_h u_mul_array (
		.clk      (clk),
		.load     (row_valid),
		.data     (h_vec),
		.weights  (w_row),
		.products (lane_products)
	);

	// reduction to one saturated Q4.12 word
	vecmat_add_tree u_add_tree (
		.clk   (clk),
		.terms (lane_products),
		.sum   (dot)
	);

endmodule

//--- bench/lstm_matvec_properties.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module lstm_matvec_properties (
	input logic clk,
	input logic reset,
	input logic row_valid,
	input logic dot_valid,
	input logic layer_done
);

	localparam int LATENCY = `MUL_STAGES + $clog2(`ARRAY_DEPTH);

	int since_reset; // stops counting at LATENCY

	always_ff @(posedge clk) begin
		if (!reset) begin
			since_reset <= 0;
		end else if (since_reset < LATENCY) begin
			since_reset <= since_reset + 1;
		end
	end

	// pipeline empty right after reset
	reset_clears_valid: assert property (@(posedge clk) !reset |=> !dot_valid)
		else $error("dot_valid high in the cycle after reset");

	valid_latency: assert property (@(posedge clk) disable iff (!reset)
		(since_reset >= LATENCY) |-> (dot_valid == $past(row_valid, LATENCY)))
		else $error("dot_valid does not follow row_valid by %0d cycles", LATENCY);

	done_needs_valid: assert property (@(posedge clk) disable iff (!reset)
		layer_done |-> dot_valid)
		else $error("layer_done high without dot_valid");

endmodule

bind lstm_matvec_top lstm_matvec_properties u_properties (
	.clk        (clk),
	.reset      (reset),
	.row_valid  (row_valid),
	.dot_valid  (dot_valid),
	.layer_done (layer_done)
);

//--- bench/tb_lstm_matvec.sv
`timescale 1ns/1ps
`include "lstm_config.svh"

module tb_lstm_matvec;

	import lstm_pkg::*;

	localparam int LANES       = `ARRAY_DEPTH;
	localparam int TREE_STAGES = $clog2(LANES);
	localparam int LATENCY     = `MUL_STAGES + TREE_STAGES;
	localparam int DOT_MAX     = (1 << (`DATA_WIDTH - 1)) - 1;
	localparam int DOT_MIN     = -(1 << (`DATA_WIDTH - 1));
	localparam int NUM_SINGLE  = 11;

	typedef fixed_t [LANES-1:0] vec_t;

	// h lane value and weight of each one-hot row
	localparam fixed_t SINGLE_H [NUM_SINGLE] = '{
		16'sh1000, 16'shE800, 16'sh0C00, 16'shE000, 16'sh0001, 16'sh0003,
		16'shFFFD, 16'sh8000, 16'sh8000, 16'sh4000, 16'sh7FFF
	};
	localparam fixed_t SINGLE_W [NUM_SINGLE] = '{
		16'sh2000, 16'sh1800, 16'shF000, 16'shD000, 16'sh0FFF, 16'sh0AAB,
		16'sh0AAB, 16'sh0800, 16'sh8000, 16'sh3000, 16'shC001
	};

	logic       clk = 1'b0;
	logic       reset;
	logic       row_valid;
	vec_t       h_vec;
	vec_t       w_row;
	fixed_t     dot;
	logic       dot_valid;
	row_index_t dot_index;
	logic       layer_done;

	fixed_t exp_dot_q [$]; // oldest row first
	int     exp_index_q [$];
	int     exp_cycle_q [$];

	int cycle_count      = 0;
	int rows_sent        = 0; // since the last reset
	int error_count      = 0;
	int monitor_errors   = 0;
	int layer_done_count = 0;
	int tests_passed     = 0;
	int tests_failed     = 0;

	lstm_matvec_top dut0 (
		.clk        (clk),
		.reset      (reset),
		.row_valid  (row_valid),
		.h_vec      (h_vec),
		.w_row      (w_row),
		.dot        (dot),
		.dot_valid  (dot_valid),
		.dot_index  (dot_index),
		.layer_done (layer_done)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// sign-magnitude product, Q4.12 slice of the magnitude
	function automatic fixed_t lane_product(input fixed_t a, input fixed_t b);
		int mag_a;
		int mag_b;
		int slice;
		int result;
		mag_a = (a < 0) ? -int'(a) : int'(a);
		mag_b = (b < 0) ? -int'(b) : int'(b);
		slice = ((mag_a * mag_b) >>> `FRAC_BITS) & 'h7FFF; // high bits lost
		result = ((a < 0) != (b < 0)) ? -slice : slice;
		return fixed_t'(result);
	endfunction

	function automatic fixed_t row_dot(input vec_t h, input vec_t w);
		tree_sum_t total;
		total = '0;
		for (int i = 0; i < LANES; i++) begin
			total = total + tree_sum_t'(lane_product(h[i], w[i]));
		end
		if (total > DOT_MAX) begin
			total = DOT_MAX;
		end else if (total < DOT_MIN) begin
			total = DOT_MIN;
		end
		return fixed_t'(total);
	endfunction

	// span 0 gives the full word range
	function automatic vec_t random_vec(input int span);
		vec_t v;
		for (int i = 0; i < LANES; i++) begin
			if (span == 0) begin
				v[i] = fixed_t'($urandom);
			end else begin
				v[i] = fixed_t'(int'($urandom_range(2 * span - 1)) - span);
			end
		end
		return v;
	endfunction

	function automatic vec_t fill_vec(input fixed_t value);
		vec_t v;
		for (int i = 0; i < LANES; i++) begin
			v[i] = value;
		end
		return v;
	endfunction

	function automatic int total_errors();
		return error_count + monitor_errors;
	endfunction

	always @(negedge clk) begin : result_monitor
		fixed_t exp_dot;
		int     exp_index;
		int     exp_cycle;
		if (cycle_count > 0) begin
			if (dot_valid === 1'b1) begin
				assert (exp_dot_q.size() != 0) else begin
					$display("%0t: dot_valid pulsed with no row outstanding", $time);
					monitor_errors++;
				end
				if (exp_dot_q.size() != 0) begin
					exp_dot   = exp_dot_q.pop_front();
					exp_index = exp_index_q.pop_front();
					exp_cycle = exp_cycle_q.pop_front();
					assert (cycle_count == exp_cycle) else begin
						$display("[FAIL] %0t dot_valid cycle expected %0d actual %0d",
							$time, exp_cycle, cycle_count);
						monitor_errors++;
					end
					assert (dot === exp_dot) else begin
						$display("[FAIL] %0t dot expected %h actual %h", $time, exp_dot, dot);
						monitor_errors++;
					end
					assert (dot_index === row_index_t'(exp_index)) else begin
						$display("[FAIL] %0t dot_index expected %0d actual %0d",
							$time, exp_index, dot_index);
						monitor_errors++;
					end
					assert (layer_done === (exp_index == LANES - 1)) else begin
						$display("[FAIL] %0t layer_done expected %b actual %b",
							$time, exp_index == LANES - 1, layer_done);
						monitor_errors++;
					end
				end
				if (layer_done === 1'b1) begin
					layer_done_count++;
				end
			end else begin
				assert (dot_valid === 1'b0) else begin
					$display("[FAIL] %0t dot_valid expected 0 actual %b", $time, dot_valid);
					monitor_errors++;
				end
				assert (layer_done === 1'b0) else begin
					$display("[FAIL] %0t layer_done expected 0 actual %b", $time, layer_done);
					monitor_errors++;
				end
			end
		end
	end

	// call right after a falling edge
	task automatic send_row(input vec_t h, input vec_t w);
		h_vec     = h;
		w_row     = w;
		row_valid = 1'b1;
		exp_dot_q.push_back(row_dot(h, w));
		exp_index_q.push_back(rows_sent % LANES);
		exp_cycle_q.push_back(cycle_count + LATENCY);
		rows_sent++;
		@(negedge clk);
		row_valid = 1'b0;
	endtask

	task automatic wait_results(input int limit);
		int waited;
		waited = 0;
		while (exp_dot_q.size() != 0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		assert (exp_dot_q.size() == 0) else begin
			$display("timeout: %0d results still missing after %0d cycles",
				exp_dot_q.size(), limit);
			error_count++;
			exp_dot_q.delete();
			exp_index_q.delete();
			exp_cycle_q.delete();
		end
	endtask

	task automatic apply_reset();
		reset = 1'b0;
		repeat (5) @(negedge clk);
		reset     = 1'b1;
		rows_sent = 0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (total_errors() == errors_before) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, total_errors() - errors_before);
		end
	endtask

	task automatic reset_state();
		int errors_before;
		errors_before = total_errors();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			if (i == 4) begin
				reset = 1'b1; // after 5 rising edges
			end
			assert (dot_valid === 1'b0) else begin
				$display("[FAIL] %0t dot_valid expected 0 actual %b", $time, dot_valid);
				error_count++;
			end
			assert (layer_done === 1'b0) else begin
				$display("[FAIL] %0t layer_done expected 0 actual %b", $time, layer_done);
				error_count++;
			end
		end
		send_row(random_vec(0), random_vec(32)); // must come out as row 0
		wait_results(4 * LATENCY);
		report_test("reset_state", errors_before);
	endtask

	task automatic single_lane_products();
		int   errors_before;
		int   lane;
		vec_t h;
		vec_t w;
		errors_before = total_errors();
		for (int c = 0; c < NUM_SINGLE; c++) begin
			lane    = (c * 7 + 3) % LANES;
			h       = random_vec(0);
			w       = '0;
			h[lane] = SINGLE_H[c];
			w[lane] = SINGLE_W[c];
			send_row(h, w);
		end
		wait_results(NUM_SINGLE + 4 * LATENCY);
		report_test("single_lane_products", errors_before);
	endtask

	task automatic full_dot_products();
		int errors_before;
		errors_before = total_errors();
		for (int r = 0; r < 24; r++) begin
			send_row(random_vec(0), random_vec(32)); // small weights stay in range
		end
		wait_results(24 + 4 * LATENCY);
		report_test("full_dot_products", errors_before);
	endtask

	task automatic saturation();
		int   errors_before;
		vec_t h;
		errors_before = total_errors();
		send_row(fill_vec(16'sh7000), fill_vec(16'sh1000));
		send_row(fill_vec(16'sh7000), fill_vec(16'shF000));
		for (int i = 0; i < LANES; i++) begin
			h[i] = fixed_t'(16'h4000 + $urandom_range(16'h3FFF));
		end
		send_row(h, fill_vec(16'shF000));
		send_row(fill_vec(16'sh8000), fill_vec(16'shF800)); // -8 times -0.5 per lane
		wait_results(4 + 4 * LATENCY);
		report_test("saturation", errors_before);
	endtask

	task automatic layer_streaming();
		int errors_before;
		int done_before;
		int gap;
		errors_before = total_errors();
		apply_reset();
		done_before = layer_done_count;
		for (int r = 0; r < LANES; r++) begin
			send_row(random_vec(0), random_vec(32));
		end
		for (int r = 0; r < LANES; r++) begin
			gap = int'($urandom_range(3));
			repeat (gap) @(negedge clk);
			send_row(random_vec(0), random_vec(32));
		end
		wait_results(4 * LANES + 4 * LATENCY);
		assert (layer_done_count - done_before == 2) else begin
			$display("[FAIL] %0t layer_done pulses expected 2 actual %0d",
				$time, layer_done_count - done_before);
			error_count++;
		end
		report_test("layer_streaming", errors_before);
	endtask

	initial begin
		reset     = 1'b0;
		row_valid = 1'b0;
		h_vec     = '0;
		w_row     = '0;
		void'($urandom(32'h8d83_41f6));
		reset_state();
		single_lane_products();
		full_dot_products();
		saturation();
		layer_streaming();
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+common
common/lstm_pkg.sv
source/signed_mul.sv
vecmat/vecmat_mul_h.sv
vecmat/vecmat_add_tree.sv
source/row_sequencer.sv
source/lstm_matvec_top.sv
bench/lstm_matvec_properties.sv
bench/tb_lstm_matvec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the LSTM matrix-vector testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	-f flist.f \
	--top-module tb_lstm_matvec \
	--Mdir obj_dir \
	-o tb_lstm_matvec

./obj_dir/tb_lstm_matvec 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
